// ==== host_cmd_pkg.sv ====
// Host command package
// Describes the 32-bit command word and the two ways the shim decodes it
`default_nettype none

package host_cmd_pkg;

    // Width of one host command word
    localparam int HOST_CMD_W = 32;

    // Operation codes, code 3 is never issued by the host
    typedef enum logic [1:0]
    {
        OP_READ  = 2'd0,
        OP_WRITE = 2'd1,
        OP_FILL  = 2'd2
    } t_host_op;

    // Single-word read or write. The reserved field pads the word to full width
    typedef struct packed
    {
        t_host_op               op;
        logic [HOST_CMD_W-27:0] rsvd;
        logic [7:0]             addr;
        logic [15:0]            data;
    } t_mem_access;

    // Background fill of count words starting at base
    typedef struct packed
    {
        t_host_op    op;
        logic [5:0]  count;
        logic [7:0]  base;
        logic [15:0] pattern;
    } t_fill_cmd;

    // Op sits at the top of both views and picks which one applies
    typedef union packed
    {
        t_mem_access acc;
        t_fill_cmd   fill;
    } t_host_cmd;

    // Shim FSM encodings
    localparam logic [1:0] SHIM_IDLE     = 2'd0;
    localparam logic [1:0] SHIM_DISPATCH = 2'd1;
    localparam logic [1:0] SHIM_RESPOND  = 2'd2;
    localparam logic [1:0] SHIM_RELEASE  = 2'd3;

endpackage

`default_nettype wire

// ==== local_mem_pkg.sv ====
// Local-memory package
// Geometry of the single bank and the number of clients sharing it
`default_nettype none

package local_mem_pkg;

    // Bank is 256 words of 16 bits
    localparam int LMEM_ADDR_W = 8;
    localparam int LMEM_DATA_W = 16;
    localparam int LMEM_DEPTH  = 256;

    // A fill runs at most 63 words
    localparam int FILL_COUNT_W = 6;

    // Client 0 is the access port, client 1 the fill engine
    localparam int NUM_MEM_CLIENTS = 2;

endpackage

`default_nettype wire

// ==== local_mem_bank.sv ====
// Local-memory bank
// Single-port array with synchronous write and registered read
`timescale 1ns/10ps
`default_nettype none

module local_mem_bank
(
    input  logic                                  ccip_to_afu,
    input  logic                                  bank_en,
    input  logic                                  bank_we,
    input  logic [local_mem_pkg::LMEM_ADDR_W-1:0] bank_addr,
    input  logic [local_mem_pkg::LMEM_DATA_W-1:0] bank_wdata,
    output logic [local_mem_pkg::LMEM_DATA_W-1:0] bank_rdata
);
    import local_mem_pkg::*;

    // Contents are undefined until written
    logic [LMEM_DATA_W-1:0] mem [LMEM_DEPTH];

    // One operation per enabled cycle, read data follows a cycle later
    always_ff @(posedge ccip_to_afu)
    begin
        if (bank_en)
        begin
            if (bank_we)
            begin
                mem[bank_addr] <= bank_wdata;
            end
            else
            begin
                bank_rdata <= mem[bank_addr];
            end
        end
    end

endmodule

`default_nettype wire

// ==== lmem_arbiter.sv ====
// Local-memory arbiter
// Round-robin grant of the bank to its clients, read data routed back
`timescale 1ns/10ps
`default_nettype none

module lmem_arbiter
(
    input  logic                                                                ccip_to_afu,
    input  logic                                                                arst_n,
    input  logic [local_mem_pkg::NUM_MEM_CLIENTS-1:0]                           mem_req,
    input  logic [local_mem_pkg::NUM_MEM_CLIENTS-1:0]                           mem_we,
    input  logic [local_mem_pkg::NUM_MEM_CLIENTS-1:0][local_mem_pkg::LMEM_ADDR_W-1:0] mem_addr,
    input  logic [local_mem_pkg::NUM_MEM_CLIENTS-1:0][local_mem_pkg::LMEM_DATA_W-1:0] mem_wdata,
    output logic [local_mem_pkg::NUM_MEM_CLIENTS-1:0]                           mem_gnt,
    output logic [local_mem_pkg::NUM_MEM_CLIENTS-1:0]                           mem_rvalid,
    output logic [local_mem_pkg::LMEM_DATA_W-1:0]                               mem_rdata,
    output logic                                                                bank_en,
    output logic                                                                bank_we,
    output logic [local_mem_pkg::LMEM_ADDR_W-1:0]                               bank_addr,
    output logic [local_mem_pkg::LMEM_DATA_W-1:0]                               bank_wdata,
    input  logic [local_mem_pkg::LMEM_DATA_W-1:0]                               bank_rdata
);
    import local_mem_pkg::*;

    localparam int CW = $clog2(NUM_MEM_CLIENTS);

    logic [CW-1:0]              last_q;
    logic [CW-1:0]              gnt_idx;
    logic [NUM_MEM_CLIENTS-1:0] rd_pend_q;

    // ==================================================
    // Round-robin select
    // ==================================================

    // Search starts just past the last winner
    always_comb
    begin
        int idx;
        mem_gnt = '0;
        gnt_idx = '0;
        for (int k = 1; k <= NUM_MEM_CLIENTS; k++)
        begin
            idx = (int'(last_q) + k) % NUM_MEM_CLIENTS;
            if (mem_req[idx] && mem_gnt == '0)
            begin
                mem_gnt[idx] = 1'b1;
                gnt_idx      = CW'(idx);
            end
        end
    end

    // Winner drives the bank in the grant cycle
    assign bank_en    = |mem_gnt;
    assign bank_we    = mem_we[gnt_idx];
    assign bank_addr  = mem_addr[gnt_idx];
    assign bank_wdata = mem_wdata[gnt_idx];

    // Shared read bus, the rvalid pulse tells who owns it
    assign mem_rdata  = bank_rdata;
    assign mem_rvalid = rd_pend_q;

    always_ff @(posedge ccip_to_afu or negedge arst_n)
    begin
        if (!arst_n)
        begin
            // Last winner is the top client so client 0 leads after reset
            last_q    <= CW'(NUM_MEM_CLIENTS - 1);
            rd_pend_q <= '0;
        end
        else
        begin
            if (bank_en)
            begin
                last_q <= gnt_idx;
            end
            rd_pend_q <= mem_gnt & ~mem_we;
        end
    end

    // A grant goes to one client at most, and only to one that asked
    gnt_onehot: assert property (@(posedge ccip_to_afu) disable iff (!arst_n)
        $onehot0(mem_gnt) && ((mem_gnt & ~mem_req) == '0));

endmodule

`default_nettype wire

// ==== fill_engine.sv ====
// Fill engine
// Writes an incrementing pattern over a run of addresses in the background
`timescale 1ns/10ps
`default_nettype none

module fill_engine
(
    input  logic                                   ccip_to_afu,
    input  logic                                   arst_n,
    input  logic                                   fill_req,
    input  logic [local_mem_pkg::LMEM_ADDR_W-1:0]  fill_base,
    input  logic [local_mem_pkg::FILL_COUNT_W-1:0] fill_count,
    input  logic [local_mem_pkg::LMEM_DATA_W-1:0]  fill_pattern,
    output logic                                   fill_ack,
    output logic                                   fill_busy,
    output logic                                   mem_req,
    output logic                                   mem_we,
    output logic [local_mem_pkg::LMEM_ADDR_W-1:0]  mem_addr,
    output logic [local_mem_pkg::LMEM_DATA_W-1:0]  mem_wdata,
    input  logic                                   mem_gnt
);
    import local_mem_pkg::*;

    logic [FILL_COUNT_W-1:0] remain_q;
    logic [LMEM_ADDR_W-1:0]  addr_q;
    logic [LMEM_DATA_W-1:0]  data_q;
    logic                    accept;

    // A new command is taken only when idle and the last handshake is closed
    assign accept = fill_req && !fill_ack && !fill_busy;

    // One write request per remaining word
    assign mem_req   = fill_busy;
    assign mem_we    = |remain_q;
    assign mem_addr  = addr_q;
    assign mem_wdata = data_q;

    always_ff @(posedge ccip_to_afu or negedge arst_n)
    begin
        if (!arst_n)
        begin
            fill_ack  <= 1'b0;
            fill_busy <= 1'b0;
            remain_q  <= '0;
        end
        else
        begin
            if (accept)
            begin
                fill_ack  <= 1'b1;
                // An empty run finishes on acceptance
                fill_busy <= (fill_count != '0);
                remain_q  <= fill_count;
            end
            else if (fill_ack && !fill_req)
            begin
                fill_ack <= 1'b0;
            end

            // Advance only on a grant, busy drops after the last one
            if (fill_busy && mem_gnt)
            begin
                remain_q <= remain_q - 1'b1;
                if (remain_q == 1)
                begin
                    fill_busy <= 1'b0;
                end
            end
        end
    end

    // Address and data both wrap at their own widths
    always_ff @(posedge ccip_to_afu)
    begin
        if (accept)
        begin
            addr_q <= fill_base;
            data_q <= fill_pattern;
        end
        else if (fill_busy && mem_gnt)
        begin
            addr_q <= addr_q + 1'b1;
            data_q <= data_q + 1'b1;
        end
    end

    // Busy must never outlive the word count, or a read would go out
    busy_means_write: assert property (@(posedge ccip_to_afu) disable iff (!arst_n)
        mem_req |-> mem_we);

endmodule

`default_nettype wire

// ==== mem_access_port.sv ====
// Memory access port
// Turns one four-phase access into a single arbitrated read or write
`timescale 1ns/10ps
`default_nettype none

module mem_access_port
(
    input  logic                                  ccip_to_afu,
    input  logic                                  arst_n,
    input  logic                                  acc_req,
    input  logic                                  acc_we,
    input  logic [local_mem_pkg::LMEM_ADDR_W-1:0] acc_addr,
    input  logic [local_mem_pkg::LMEM_DATA_W-1:0] acc_wdata,
    output logic                                  acc_ack,
    output logic [local_mem_pkg::LMEM_DATA_W-1:0] acc_rdata,
    output logic                                  mem_req,
    output logic                                  mem_we,
    output logic [local_mem_pkg::LMEM_ADDR_W-1:0] mem_addr,
    output logic [local_mem_pkg::LMEM_DATA_W-1:0] mem_wdata,
    input  logic                                  mem_gnt,
    input  logic                                  mem_rvalid,
    input  logic [local_mem_pkg::LMEM_DATA_W-1:0] mem_rdata
);
    // Read granted, data still in flight from the bank
    logic rd_wait_q;

    // The shim holds these stable for the whole access
    assign mem_we    = acc_we;
    assign mem_addr  = acc_addr;
    assign mem_wdata = acc_wdata;

    always_ff @(posedge ccip_to_afu or negedge arst_n)
    begin
        if (!arst_n)
        begin
            mem_req   <= 1'b0;
            rd_wait_q <= 1'b0;
            acc_ack   <= 1'b0;
        end
        else if (acc_ack)
        begin
            // Hold the ack until the shim lets go of its request
            if (!acc_req)
            begin
                acc_ack <= 1'b0;
            end
        end
        else if (mem_req)
        begin
            // The grant cycle is the bank cycle, a write is done right here
            if (mem_gnt)
            begin
                mem_req   <= 1'b0;
                rd_wait_q <= !acc_we;
                acc_ack   <= acc_we;
            end
        end
        else if (rd_wait_q)
        begin
            if (mem_rvalid)
            begin
                rd_wait_q <= 1'b0;
                acc_ack   <= 1'b1;
            end
        end
        else if (acc_req)
        begin
            mem_req <= 1'b1;
        end
    end

    // Read data lands one cycle after the grant
    always_ff @(posedge ccip_to_afu)
    begin
        if (mem_rvalid)
        begin
            acc_rdata <= mem_rdata;
        end
    end

endmodule

`default_nettype wire

// ==== platform_shim.sv ====
// Platform shim
// Ends the host four-phase link, decodes each command word and hands it
// to the access port or the fill engine over their own four-phase links
`timescale 1ns/10ps
`default_nettype none

module platform_shim
(
    input  logic                                    ccip_to_afu,
    input  logic                                    arst_n,
    input  logic                                    cmd_req,
    input  host_cmd_pkg::t_host_cmd                 cmd_word,
    output logic                                    cmd_ack,
    output logic [local_mem_pkg::LMEM_DATA_W-1:0]   rsp_data,
    output logic                                    acc_req,
    output logic                                    acc_we,
    output logic [local_mem_pkg::LMEM_ADDR_W-1:0]   acc_addr,
    output logic [local_mem_pkg::LMEM_DATA_W-1:0]   acc_wdata,
    input  logic                                    acc_ack,
    input  logic [local_mem_pkg::LMEM_DATA_W-1:0]   acc_rdata,
    output logic                                    fill_req,
    output logic [local_mem_pkg::LMEM_ADDR_W-1:0]   fill_base,
    output logic [local_mem_pkg::FILL_COUNT_W-1:0]  fill_count,
    output logic [local_mem_pkg::LMEM_DATA_W-1:0]   fill_pattern,
    input  logic                                    fill_ack
);
    import host_cmd_pkg::*;

    logic [1:0] state_q;
    t_host_cmd  cmd_q;
    logic       is_fill;
    logic       client_ack;

    // ==================================================
    // Command decode
    // ==================================================

    // The op field is common to both views of the latched word
    assign is_fill    = (cmd_q.acc.op == OP_FILL);
    assign client_ack = is_fill ? fill_ack : acc_ack;

    // Access view
    assign acc_we    = (cmd_q.acc.op == OP_WRITE);
    assign acc_addr  = cmd_q.acc.addr;
    assign acc_wdata = cmd_q.acc.data;

    // Fill view of the same bits
    assign fill_base    = cmd_q.fill.base;
    assign fill_count   = cmd_q.fill.count;
    assign fill_pattern = cmd_q.fill.pattern;

    // Word is captured once, as the request is accepted
    always_ff @(posedge ccip_to_afu)
    begin
        if (state_q == SHIM_IDLE && cmd_req)
        begin
            cmd_q <= cmd_word;
        end
    end

    // ==================================================
    // Handshake FSM
    // ==================================================

    always_ff @(posedge ccip_to_afu or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state_q  <= SHIM_IDLE;
            cmd_ack  <= 1'b0;
            acc_req  <= 1'b0;
            fill_req <= 1'b0;
            rsp_data <= '0;
        end
        else
        begin
            case (state_q)
                SHIM_IDLE:
                begin
                    // Back in idle the host has already dropped its last request,
                    // so a high cmd_req here is always a fresh command
                    if (cmd_req)
                    begin
                        acc_req  <= (cmd_word.acc.op != OP_FILL);
                        fill_req <= (cmd_word.acc.op == OP_FILL);
                        state_q  <= SHIM_DISPATCH;
                    end
                end
                SHIM_DISPATCH:
                begin
                    // Client done, so release it and answer the host
                    if (client_ack)
                    begin
                        acc_req  <= 1'b0;
                        fill_req <= 1'b0;
                        cmd_ack  <= 1'b1;
                        rsp_data <= (cmd_q.acc.op == OP_READ) ? acc_rdata : '0;
                        state_q  <= SHIM_RESPOND;
                    end
                end
                SHIM_RESPOND:
                begin
                    if (!cmd_req)
                    begin
                        cmd_ack <= 1'b0;
                        state_q <= SHIM_RELEASE;
                    end
                end
                default:
                begin
                    // Wait for the client to close its own four-phase cycle
                    if (!client_ack)
                    begin
                        state_q <= SHIM_IDLE;
                    end
                end
            endcase
        end
    end

    // ==================================================
    // Checks
    // ==================================================

    // The host must still have been requesting at the edge that raised the answer
    ack_needs_req: assert property (@(posedge ccip_to_afu) disable iff (!arst_n)
        $rose(cmd_ack) |-> $past(cmd_req));

    // Op code 3 has no meaning and must never reach the dispatcher
    no_bad_op: assert property (@(posedge ccip_to_afu) disable iff (!arst_n)
        (state_q == SHIM_IDLE && cmd_req) |-> (cmd_word.acc.op != 2'd3));

endmodule

`default_nettype wire

// ==== ccip_afu_top.sv ====
// Accelerator shell top
// Ties the shim, both memory clients, the arbiter and the bank together
`timescale 1ns/10ps
`default_nettype none

module ccip_afu_top
(
    input  logic                                  ccip_to_afu,
    input  logic                                  arst_n,
    input  logic                                  cmd_req,
    input  host_cmd_pkg::t_host_cmd               cmd_word,
    output logic                                  cmd_ack,
    output logic [local_mem_pkg::LMEM_DATA_W-1:0] rsp_data,
    output logic                                  fill_busy
);
    import local_mem_pkg::*;

    // Shim to access port
    logic                   acc_req;
    logic                   acc_we;
    logic [LMEM_ADDR_W-1:0] acc_addr;
    logic [LMEM_DATA_W-1:0] acc_wdata;
    logic                   acc_ack;
    logic [LMEM_DATA_W-1:0] acc_rdata;

    // Shim to fill engine
    logic                    fill_req;
    logic [LMEM_ADDR_W-1:0]  fill_base;
    logic [FILL_COUNT_W-1:0] fill_count;
    logic [LMEM_DATA_W-1:0]  fill_pattern;
    logic                    fill_ack;

    // Client side of the arbiter, index 0 access port and index 1 fill engine
    logic [NUM_MEM_CLIENTS-1:0]                  cli_req;
    logic [NUM_MEM_CLIENTS-1:0]                  cli_we;
    logic [NUM_MEM_CLIENTS-1:0][LMEM_ADDR_W-1:0] cli_addr;
    logic [NUM_MEM_CLIENTS-1:0][LMEM_DATA_W-1:0] cli_wdata;
    logic [NUM_MEM_CLIENTS-1:0]                  cli_gnt;
    logic [NUM_MEM_CLIENTS-1:0]                  cli_rvalid;
    logic [LMEM_DATA_W-1:0]                      cli_rdata;

    // Arbiter to bank
    logic                   bank_en;
    logic                   bank_we;
    logic [LMEM_ADDR_W-1:0] bank_addr;
    logic [LMEM_DATA_W-1:0] bank_wdata;
    logic [LMEM_DATA_W-1:0] bank_rdata;

    platform_shim u_shim
    (
        .ccip_to_afu(ccip_to_afu), .arst_n(arst_n),
        .cmd_req(cmd_req), .cmd_word(cmd_word), .cmd_ack(cmd_ack), .rsp_data(rsp_data),
        .acc_req(acc_req), .acc_we(acc_we), .acc_addr(acc_addr), .acc_wdata(acc_wdata),
        .acc_ack(acc_ack), .acc_rdata(acc_rdata),
        .fill_req(fill_req), .fill_base(fill_base), .fill_count(fill_count),
        .fill_pattern(fill_pattern), .fill_ack(fill_ack)
    );

    mem_access_port u_acc
    (
        .ccip_to_afu(ccip_to_afu), .arst_n(arst_n),
        .acc_req(acc_req), .acc_we(acc_we), .acc_addr(acc_addr), .acc_wdata(acc_wdata),
        .acc_ack(acc_ack), .acc_rdata(acc_rdata),
        .mem_req(cli_req[0]), .mem_we(cli_we[0]), .mem_addr(cli_addr[0]),
        .mem_wdata(cli_wdata[0]), .mem_gnt(cli_gnt[0]), .mem_rvalid(cli_rvalid[0]),
        .mem_rdata(cli_rdata)
    );

    // The fill engine only writes, so it takes no read return
    fill_engine u_fill
    (
        .ccip_to_afu(ccip_to_afu), .arst_n(arst_n),
        .fill_req(fill_req), .fill_base(fill_base), .fill_count(fill_count),
        .fill_pattern(fill_pattern), .fill_ack(fill_ack), .fill_busy(fill_busy),
        .mem_req(cli_req[1]), .mem_we(cli_we[1]), .mem_addr(cli_addr[1]),
        .mem_wdata(cli_wdata[1]), .mem_gnt(cli_gnt[1])
    );

    lmem_arbiter u_arb
    (
        .ccip_to_afu(ccip_to_afu), .arst_n(arst_n),
        .mem_req(cli_req), .mem_we(cli_we), .mem_addr(cli_addr), .mem_wdata(cli_wdata),
        .mem_gnt(cli_gnt), .mem_rvalid(cli_rvalid), .mem_rdata(cli_rdata),
        .bank_en(bank_en), .bank_we(bank_we), .bank_addr(bank_addr),
        .bank_wdata(bank_wdata), .bank_rdata(bank_rdata)
    );

    local_mem_bank u_bank
    (
        .ccip_to_afu(ccip_to_afu),
        .bank_en(bank_en), .bank_we(bank_we), .bank_addr(bank_addr),
        .bank_wdata(bank_wdata), .bank_rdata(bank_rdata)
    );

endmodule

`default_nettype wire

// ==== tb_ccip_afu.sv ====
// Testbench for the accelerator shell
// Replays host commands from the vector file and checks read data, fill status
// and the host four-phase handshake
`timescale 1ns/10ps
`default_nettype none

module tb_ccip_afu;
    import host_cmd_pkg::*;

    // Worst case per vector line is a 63-word fill plus the handshake
    localparam int CYCLES_PER_LINE = 150;

    logic        ccip_to_afu;
    logic        arst_n;
    logic        cmd_req;
    t_host_cmd   cmd_word;
    logic        cmd_ack;
    logic [15:0] rsp_data;
    logic        fill_busy;

    // Vector lines as read from the file
    byte         kind_q [$];
    logic [31:0] word_q [$];
    logic [15:0] exp_q  [$];

    int   cycles;
    int   limit;
    int   err_cnt;
    logic ack_prev;
    logic req_prev;

    ccip_afu_top DUT
    (
        .ccip_to_afu(ccip_to_afu),
        .arst_n(arst_n),
        .cmd_req(cmd_req),
        .cmd_word(cmd_word),
        .cmd_ack(cmd_ack),
        .rsp_data(rsp_data),
        .fill_busy(fill_busy)
    );

    // 4 ns clock period
    always #2 ccip_to_afu = ~ccip_to_afu;

    // ==================================================
    // Failure reporting
    // ==================================================

    task automatic fail_stop(input string why);
        err_cnt = err_cnt + 1;
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [15:0] exp,
                               input logic [15:0] got);
        assert (got === exp)
        else
        begin
            err_cnt = err_cnt + 1;
            $display("[FAIL] t=%0t %s expected %h got %h", $time, name, exp, got);
            $display("*** TEST FAILED ***");
            $fatal(1);
        end
    endtask

    // ==================================================
    // Vector file
    // ==================================================

    // Lines starting with # and blank lines carry no vector
    task automatic load_vectors();
        int          fd;
        int          n;
        string       line;
        byte         kind;
        logic [31:0] word;
        logic [15:0] exp;
        fd = $fopen("tb_input_vectors.txt", "r");
        assert (fd != 0) else fail_stop("Could not open tb_input_vectors.txt");
        while ($fgets(line, fd) > 0)
        begin
            if (line.len() > 1 && line.getc(0) != "#")
            begin
                n = $sscanf(line, "%c %h %h", kind, word, exp);
                assert (n == 3) else fail_stop({"Malformed vector line: ", line});
                kind_q.push_back(kind);
                word_q.push_back(word);
                exp_q.push_back(exp);
            end
        end
        $fclose(fd);
    endtask

    // ==================================================
    // Host side
    // ==================================================

    // One full four-phase cycle on the host link, driven on falling edges
    task automatic run_command(input logic [31:0] word, input logic [15:0] exp);
        logic saw_idle;
        @(negedge ccip_to_afu);
        cmd_word = word;
        cmd_req  = 1'b1;
        // A fill queued behind a running one must see the engine go idle first
        saw_idle = !fill_busy;
        while (!cmd_ack)
        begin
            @(negedge ccip_to_afu);
            if (!fill_busy)
            begin
                saw_idle = 1'b1;
            end
        end

        // Read data comes back together with the ack
        if (cmd_word.acc.op == OP_READ)
        begin
            check_value("rsp_data", exp, rsp_data);
        end
        if (cmd_word.fill.op == OP_FILL)
        begin
            assert (saw_idle)
            else fail_stop("Fill was acknowledged while the previous fill was still busy");
            // An empty run leaves no busy period behind
            if (cmd_word.fill.count == 6'd0)
            begin
                assert (!fill_busy)
                else fail_stop("fill_busy is high after a fill of zero words");
            end
        end

        cmd_req = 1'b0;
        while (cmd_ack)
        begin
            @(negedge ccip_to_afu);
        end
    endtask

    task automatic wait_fill_idle();
        while (fill_busy)
        begin
            @(negedge ccip_to_afu);
        end
    endtask

    // ==================================================
    // Handshake monitor and timeout
    // ==================================================

    // Values read here are the ones from before this edge, so an ack change
    // seen now was caused by the request level of the previous edge
    always @(posedge ccip_to_afu)
    begin
        cycles = cycles + 1;
        assert (limit == 0 || cycles <= limit)
        else fail_stop("Timeout: the vector run did not complete within the cycle limit");
        if (arst_n)
        begin
            if (cmd_ack && !ack_prev)
            begin
                assert (req_prev) else fail_stop("cmd_ack rose while cmd_req was low");
            end
            if (!cmd_ack && ack_prev)
            begin
                assert (!req_prev) else fail_stop("cmd_ack fell while cmd_req was still high");
            end
        end
        ack_prev = cmd_ack;
        req_prev = cmd_req;
    end

    // ==================================================
    // Main sequence
    // ==================================================

    initial
    begin
        int seed;
        int gap;
        ccip_to_afu = 1'b0;
        arst_n      = 1'b0;
        cmd_req     = 1'b0;
        cmd_word    = '0;
        cycles      = 0;
        limit       = 0;
        err_cnt     = 0;
        ack_prev    = 1'b0;
        req_prev    = 1'b0;
        seed        = $urandom(32'h32b);

        load_vectors();
        limit = word_q.size() * CYCLES_PER_LINE;

        repeat (4) @(negedge ccip_to_afu);
        arst_n = 1'b1;
        assert (cmd_ack == 1'b0 && fill_busy == 1'b0)
        else fail_stop("cmd_ack or fill_busy is not low after reset");

        foreach (word_q[i])
        begin
            if (kind_q[i] == "W")
            begin
                wait_fill_idle();
            end
            else if (kind_q[i] == "C")
            begin
                run_command(word_q[i], exp_q[i]);
            end
            else
            begin
                fail_stop("Unknown line kind in the vector file");
            end
            // Idle gap of 0 to 3 cycles between commands
            gap = $urandom % 4;
            repeat (gap) @(negedge ccip_to_afu);
        end

        if (err_cnt == 0)
        begin
            $display("*** TEST PASSED ***");
        end
        else
        begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb_input_vectors.txt ====
# kind word expected: C host command (expected checked on reads only), W wait for fill idle
# word is hex op[31:30] count/rsvd[29:24] addr/base[23:16] data/pattern[15:0]
C 40101234 0000
C 40115678 0000
C 00100000 1234
C 00110000 5678
C 8cf8fffa 0000
W 00000000 0000
C 00f80000 fffa
C 00fd0000 ffff
C 00030000 0005
C 80100000 0000
C 00100000 1234
C bf402000 0000
C 40087777 0000
C 00080000 7777
C 00110000 5678
C 84900300 0000
W 00000000 0000
C 00400000 2000
C 007e0000 203e
C 00930000 0303
C 00900000 0300

// ==== verilog.f ====
host_cmd_pkg.sv
local_mem_pkg.sv
local_mem_bank.sv
lmem_arbiter.sv
fill_engine.sv
mem_access_port.sv
platform_shim.sv
ccip_afu_top.sv
tb_ccip_afu.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the accelerator shell testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f --top-module tb_ccip_afu

sim_out=$(./obj_dir/Vtb_ccip_afu) || true
echo "$sim_out"

# Exits non-zero when the pass line is missing
echo "$sim_out" | grep -qF '*** TEST PASSED ***'
